/* common/fetch_pkg.sv */
// ==============================
// Address widths, fetch block geometry and FSM state type
// shared by every block of the fetch front end
// ==============================
package fetch_pkg;

  localparam int VADDR_W      = 39;               // Sv39 virtual address
  localparam int FETCH_BYTES  = 8;                // One block per request
  localparam int FETCH_DATA_W = FETCH_BYTES * 8;  // 64 bit block

  typedef logic [VADDR_W-1:0] vaddr_t;

  // Boot address after reset
  localparam vaddr_t PC_INIT_VAL = 39'h00_8000_0000;

  // ==============================
  // Fetch FSM states
  // ==============================
  typedef enum logic [2:0] {
    INIT            = 3'd0,  // One cycle after reset
    FETCH_REQ       = 3'd1,  // Streaming requests
    WAIT_IC_FILL    = 3'd2,  // Miss seen, wait for memory ready
    WAIT_IBUF_FREE  = 3'd3,  // Buffer was full at s2
    WAIT_FLUSH_FREE = 3'd4   // Redirect pending, memory busy
  } fetch_state_t;

endpackage

/* common/trap_pkg.sv */
// ==============================
// Exception cause codes and constants used to pick
// the redirect target of a committed exception
// ==============================
package trap_pkg;

  // Number of delegation bits in medeleg
  localparam int MEDELEG_W = 16;

  // Silent flush restarts at the next instruction
  localparam int SILENT_FLUSH_STEP = 4;

  // ==============================
  // Cause encoding
  // ==============================
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN  = 5'd0,
    INST_ACC_FAULT      = 5'd1,
    ILLEGAL_INST        = 5'd2,
    LOAD_ADDR_MISALIGN  = 5'd4,
    LOAD_ACC_FAULT      = 5'd5,
    STAMO_ADDR_MISALIGN = 5'd6,
    STAMO_ACC_FAULT     = 5'd7,
    ECALL_U             = 5'd8,
    ECALL_S             = 5'd9,
    ECALL_M             = 5'd11,
    INST_PAGE_FAULT     = 5'd12,
    LOAD_PAGE_FAULT     = 5'd13,
    STAMO_PAGE_FAULT    = 5'd15,
    // Values above the medeleg range are return and flush events
    MRET                = 5'd24,
    SRET                = 5'd25,
    SILENT_FLUSH        = 5'd26
  } except_t;

endpackage

/* design/fetch_redirect.sv */
// ==============================
// Picks the fetch redirect target from a committed
// exception or a branch mispredict, exception first
// ==============================
`timescale 1ns/1ps

module fetch_redirect (
  input  logic                            i_commit_valid,
  input  trap_pkg::except_t               i_commit_cause,
  input  fetch_pkg::vaddr_t               i_commit_epc,
  input  logic                            i_br_mispredict,
  input  fetch_pkg::vaddr_t               i_br_target,
  input  fetch_pkg::vaddr_t               i_mtvec,
  input  fetch_pkg::vaddr_t               i_stvec,
  input  fetch_pkg::vaddr_t               i_mepc,
  input  fetch_pkg::vaddr_t               i_sepc,
  input  logic [trap_pkg::MEDELEG_W-1:0]  i_medeleg,
  output logic                            o_flush_valid,
  output fetch_pkg::vaddr_t               o_flush_vaddr
);

  localparam int DELEG_IDX_W = $clog2(trap_pkg::MEDELEG_W);

  logic [4:0] w_cause;
  logic       w_has_deleg_bit;
  logic       w_trap_deleg;

  assign w_cause = i_commit_cause;

  // Each trap cause indexes its own medeleg bit
  assign w_has_deleg_bit = (int'(w_cause) < trap_pkg::MEDELEG_W);
  assign w_trap_deleg    = w_has_deleg_bit & i_medeleg[w_cause[DELEG_IDX_W-1:0]];

  // ==============================
  // Target select
  // ==============================
  always_comb begin
    o_flush_vaddr = '0;
    if (i_commit_valid) begin
      case (i_commit_cause)
        trap_pkg::SILENT_FLUSH: begin
          o_flush_vaddr = i_commit_epc +
                          fetch_pkg::vaddr_t'(trap_pkg::SILENT_FLUSH_STEP);
        end
        trap_pkg::MRET: o_flush_vaddr = i_mepc;
        trap_pkg::SRET: o_flush_vaddr = i_sepc;
        default: begin
          o_flush_vaddr = w_trap_deleg ? i_stvec : i_mtvec;  // S-mode handler if delegated
        end
      endcase
    end else if (i_br_mispredict) begin
      o_flush_vaddr = i_br_target;
    end
  end

  assign o_flush_valid = i_commit_valid | i_br_mispredict;

endmodule

/* fetch/fetch_pc_ctrl.sv */
// ==============================
// Fetch FSM and s0 address register, issues memory
// requests and picks the next fetch address
// ==============================
`timescale 1ns/1ps

module fetch_pc_ctrl (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush_valid,
  input  fetch_pkg::vaddr_t i_flush_vaddr,
  input  logic              i_mem_ready,
  input  logic              i_mem_miss,
  input  logic              i_s2_valid,
  input  logic              i_s2_clear,
  input  fetch_pkg::vaddr_t i_s2_vaddr,
  input  logic              i_ibuf_ready,
  output logic              o_req_valid,
  output fetch_pkg::vaddr_t o_req_vaddr
);

  localparam fetch_pkg::vaddr_t BLK_STEP = fetch_pkg::vaddr_t'(fetch_pkg::FETCH_BYTES);
  localparam fetch_pkg::vaddr_t BLK_MASK = ~(BLK_STEP - 1'b1);

  fetch_pkg::fetch_state_t r_state;
  fetch_pkg::fetch_state_t w_state_next;
  fetch_pkg::fetch_state_t w_flush_state;
  fetch_pkg::vaddr_t       r_s0_vaddr;
  fetch_pkg::vaddr_t       w_s0_vaddr_next;
  logic                    w_s2_live;
  logic                    w_s2_miss;
  logic                    w_s2_full;
  logic                    w_s2_refetch;
  logic                    w_req_fire;

  assign w_s2_live    = i_s2_valid & ~i_s2_clear;
  assign w_s2_miss    = w_s2_live & i_mem_miss;
  assign w_s2_full    = w_s2_live & ~i_mem_miss & ~i_ibuf_ready;  // Hit but no room
  assign w_s2_refetch = (r_state == fetch_pkg::FETCH_REQ) & (w_s2_miss | w_s2_full);

  // Redirect goes out now if memory takes it, else it is parked
  assign w_flush_state = i_mem_ready ? fetch_pkg::FETCH_REQ : fetch_pkg::WAIT_FLUSH_FREE;

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      fetch_pkg::INIT: begin
        w_state_next = fetch_pkg::FETCH_REQ;
      end
      fetch_pkg::FETCH_REQ: begin
        if (i_flush_valid) begin
          w_state_next = w_flush_state;
        end else if (w_s2_miss) begin
          w_state_next = fetch_pkg::WAIT_IC_FILL;
        end else if (w_s2_full) begin
          w_state_next = fetch_pkg::WAIT_IBUF_FREE;
        end
      end
      fetch_pkg::WAIT_IC_FILL, fetch_pkg::WAIT_FLUSH_FREE: begin
        if (i_flush_valid) begin
          w_state_next = w_flush_state;
        end else if (i_mem_ready) begin
          w_state_next = fetch_pkg::FETCH_REQ;  // Fill done or target can go out
        end
      end
      fetch_pkg::WAIT_IBUF_FREE: begin
        if (i_flush_valid) begin
          w_state_next = w_flush_state;
        end else if (i_mem_ready & i_ibuf_ready) begin
          w_state_next = fetch_pkg::FETCH_REQ;
        end
      end
      default: begin
        w_state_next = fetch_pkg::INIT;
      end
    endcase
  end

  // ==============================
  // Request and next address
  // ==============================
  assign o_req_valid = (r_state != fetch_pkg::INIT) & (w_state_next == fetch_pkg::FETCH_REQ);
  assign o_req_vaddr = i_flush_valid ? i_flush_vaddr : r_s0_vaddr;
  assign w_req_fire  = o_req_valid & i_mem_ready;

  always_comb begin
    w_s0_vaddr_next = r_s0_vaddr;
    if (w_req_fire) begin
      w_s0_vaddr_next = (o_req_vaddr & BLK_MASK) + BLK_STEP;  // Next sequential block
    end else if (i_flush_valid) begin
      w_s0_vaddr_next = i_flush_vaddr;                        // Hold target until ready
    end else if (w_s2_refetch) begin
      w_s0_vaddr_next = i_s2_vaddr;                           // Replay the s2 block
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= fetch_pkg::INIT;
      r_s0_vaddr <= fetch_pkg::PC_INIT_VAL;
    end else begin
      r_state    <= w_state_next;
      r_s0_vaddr <= w_s0_vaddr_next;
    end
  end

endmodule

/* fetch/fetch_pipe.sv */
// ==============================
// Tracks accepted requests through s1 and s2 until the
// memory answers, and kills stale items
// ==============================
`timescale 1ns/1ps

module fetch_pipe (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush_valid,
  input  logic              i_req_fire,
  input  fetch_pkg::vaddr_t i_req_vaddr,
  input  logic              i_mem_resp_valid,
  input  logic              i_ibuf_ready,
  output logic              o_s2_valid,
  output logic              o_s2_clear,
  output fetch_pkg::vaddr_t o_s2_vaddr,
  output logic              o_ibuf_write
);

  logic              r_s1_valid;
  fetch_pkg::vaddr_t r_s1_vaddr;
  logic              r_s2_valid;
  logic              r_s2_clear;
  fetch_pkg::vaddr_t r_s2_vaddr;
  logic              w_s2_live;
  logic              w_s2_retry;
  logic              w_kill;

  assign w_s2_live  = r_s2_valid & ~r_s2_clear;
  // Miss or full buffer both force a refetch from s2
  assign w_s2_retry = w_s2_live & ~(i_mem_resp_valid & i_ibuf_ready);
  assign w_kill     = i_flush_valid | w_s2_retry;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_clear <= 1'b0;
    end else begin
      r_s1_valid <= i_req_fire;
      r_s2_valid <= r_s1_valid;
      r_s2_clear <= r_s1_valid & w_kill;  // Issued before the kill
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req_fire) begin
      r_s1_vaddr <= i_req_vaddr;
    end
    r_s2_vaddr <= r_s1_vaddr;
  end

  assign o_s2_valid   = r_s2_valid;
  assign o_s2_clear   = r_s2_clear;
  assign o_s2_vaddr   = r_s2_vaddr;
  assign o_ibuf_write = w_s2_live & i_mem_resp_valid & i_ibuf_ready;

endmodule

/* design/inst_buffer.sv */
// ==============================
// Circular FIFO of fetched blocks toward decode,
// emptied by a redirect
// ==============================
`timescale 1ns/1ps

module inst_buffer #(
  parameter int IBUF_DEPTH = 4
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_flush_valid,
  input  logic                                i_write,
  input  fetch_pkg::vaddr_t                   i_write_pc,
  input  logic [fetch_pkg::FETCH_DATA_W-1:0]  i_write_data,
  output logic                                o_ready,
  output logic                                o_inst_valid,
  output fetch_pkg::vaddr_t                   o_inst_pc,
  output logic [fetch_pkg::FETCH_DATA_W-1:0]  o_inst_data,
  input  logic                                i_inst_ready
);

  localparam int               IDX_W    = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(IBUF_DEPTH - 1);
  localparam logic [IDX_W:0]   FULL_CNT = (IDX_W + 1)'(IBUF_DEPTH);

  fetch_pkg::vaddr_t                 r_pc   [IBUF_DEPTH];
  logic [fetch_pkg::FETCH_DATA_W-1:0] r_data [IBUF_DEPTH];
  logic [IDX_W-1:0]                  r_wr_idx;
  logic [IDX_W-1:0]                  r_rd_idx;
  logic [IDX_W:0]                    r_count;
  logic                              w_push;
  logic                              w_pop;

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (idx == LAST_IDX) ? '0 : idx + 1'b1;
  endfunction

  assign o_ready      = (r_count != FULL_CNT);
  assign o_inst_valid = (r_count != '0);
  assign o_inst_pc    = r_pc[r_rd_idx];
  assign o_inst_data  = r_data[r_rd_idx];

  assign w_push = i_write & o_ready;
  assign w_pop  = o_inst_valid & i_inst_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_idx <= '0;
      r_rd_idx <= '0;
      r_count  <= '0;
    end else if (i_flush_valid) begin  // Drop everything, incoming write too
      r_wr_idx <= '0;
      r_rd_idx <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_idx <= next_idx(r_wr_idx);
      end
      if (w_pop) begin
        r_rd_idx <= next_idx(r_rd_idx);
      end
      r_count <= r_count + {{IDX_W{1'b0}}, w_push} - {{IDX_W{1'b0}}, w_pop};
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_pc[r_wr_idx]   <= i_write_pc;
      r_data[r_wr_idx] <= i_write_data;
    end
  end

endmodule

/* design/frontend_fetch.sv */
// ==============================
// Fetch front end top, connects redirect select, PC FSM,
// the s1/s2 pipeline and the instruction buffer
// ==============================
`timescale 1ns/1ps

module frontend_fetch #(
  parameter int IBUF_DEPTH = 4
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  // Commit and branch redirect
  input  logic                                i_commit_valid,
  input  trap_pkg::except_t                   i_commit_cause,
  input  fetch_pkg::vaddr_t                   i_commit_epc,
  input  logic                                i_br_mispredict,
  input  fetch_pkg::vaddr_t                   i_br_target,
  // CSR levels
  input  fetch_pkg::vaddr_t                   i_mtvec,
  input  fetch_pkg::vaddr_t                   i_stvec,
  input  fetch_pkg::vaddr_t                   i_mepc,
  input  fetch_pkg::vaddr_t                   i_sepc,
  input  logic [trap_pkg::MEDELEG_W-1:0]      i_medeleg,
  // Instruction memory
  output logic                                o_mem_req_valid,
  output fetch_pkg::vaddr_t                   o_mem_req_vaddr,
  input  logic                                i_mem_ready,
  input  logic                                i_mem_resp_valid,
  input  logic [fetch_pkg::FETCH_DATA_W-1:0]  i_mem_resp_data,
  input  logic                                i_mem_miss,
  // Decode
  output logic                                o_inst_valid,
  output fetch_pkg::vaddr_t                   o_inst_pc,
  output logic [fetch_pkg::FETCH_DATA_W-1:0]  o_inst_data,
  input  logic                                i_inst_ready
);

  logic              w_flush_valid;
  fetch_pkg::vaddr_t w_flush_vaddr;
  logic              w_req_fire;
  logic              w_s2_valid;
  logic              w_s2_clear;
  fetch_pkg::vaddr_t w_s2_vaddr;
  logic              w_ibuf_write;
  logic              w_ibuf_ready;

  assign w_req_fire = o_mem_req_valid & i_mem_ready;  // Memory accepted s0

  fetch_redirect u_redirect (
    .i_commit_valid  (i_commit_valid),
    .i_commit_cause  (i_commit_cause),
    .i_commit_epc    (i_commit_epc),
    .i_br_mispredict (i_br_mispredict),
    .i_br_target     (i_br_target),
    .i_mtvec         (i_mtvec),
    .i_stvec         (i_stvec),
    .i_mepc          (i_mepc),
    .i_sepc          (i_sepc),
    .i_medeleg       (i_medeleg),
    .o_flush_valid   (w_flush_valid),
    .o_flush_vaddr   (w_flush_vaddr)
  );

  fetch_pc_ctrl u_pc_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush_valid (w_flush_valid),
    .i_flush_vaddr (w_flush_vaddr),
    .i_mem_ready   (i_mem_ready),
    .i_mem_miss    (i_mem_miss),
    .i_s2_valid    (w_s2_valid),
    .i_s2_clear    (w_s2_clear),
    .i_s2_vaddr    (w_s2_vaddr),
    .i_ibuf_ready  (w_ibuf_ready),
    .o_req_valid   (o_mem_req_valid),
    .o_req_vaddr   (o_mem_req_vaddr)
  );

  fetch_pipe u_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_flush_valid    (w_flush_valid),
    .i_req_fire       (w_req_fire),
    .i_req_vaddr      (o_mem_req_vaddr),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_ibuf_ready     (w_ibuf_ready),
    .o_s2_valid       (w_s2_valid),
    .o_s2_clear       (w_s2_clear),
    .o_s2_vaddr       (w_s2_vaddr),
    .o_ibuf_write     (w_ibuf_write)
  );

  inst_buffer #(
    .IBUF_DEPTH (IBUF_DEPTH)
  ) u_ibuf (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush_valid (w_flush_valid),
    .i_write       (w_ibuf_write),
    .i_write_pc    (w_s2_vaddr),
    .i_write_data  (i_mem_resp_data),
    .o_ready       (w_ibuf_ready),
    .o_inst_valid  (o_inst_valid),
    .o_inst_pc     (o_inst_pc),
    .o_inst_data   (o_inst_data),
    .i_inst_ready  (i_inst_ready)
  );

endmodule

/* verif/frontend_fetch_properties.sv */
// ==============================
// Concurrent checks on reset, flush and memory response,
// bound into every frontend_fetch instance
// ==============================
`timescale 1ns/1ps

module frontend_fetch_properties (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_flush_valid,
  input logic i_inst_valid,
  input logic i_mem_req_valid,
  input logic i_mem_ready,
  input logic i_mem_resp_valid,
  input logic i_mem_miss
);

  int assert_fail_cnt = 0;

  // Buffer is empty right after a redirect
  flush_empties_buffer: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_flush_valid |=> !i_inst_valid
  ) else begin
    $error("o_inst_valid high in the cycle after a flush");
    assert_fail_cnt++;
  end

  quiet_in_reset: assert property (
    @(posedge i_clk) !i_reset_n |-> (!i_inst_valid && !i_mem_req_valid)
  ) else begin
    $error("o_inst_valid or o_mem_req_valid high during reset");
    assert_fail_cnt++;
  end

  // Exactly one answer per accepted request
  single_response: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      (i_mem_req_valid && i_mem_ready) |-> ##2 (i_mem_resp_valid != i_mem_miss)
  ) else begin
    $error("Memory gave no single hit or miss two cycles after a request");
    assert_fail_cnt++;
  end

endmodule

bind frontend_fetch frontend_fetch_properties u_props (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_flush_valid    (w_flush_valid),
  .i_inst_valid     (o_inst_valid),
  .i_mem_req_valid  (o_mem_req_valid),
  .i_mem_ready      (i_mem_ready),
  .i_mem_resp_valid (i_mem_resp_valid),
  .i_mem_miss       (i_mem_miss)
);

/* verif/tb_frontend_fetch.sv */
// ==============================
// Testbench for the fetch front end. Memory and decode models,
// redirect events from the stimulus file, in-order block checker
// ==============================
`timescale 1ns/1ps

module tb_frontend_fetch;

  localparam int    CLK_HALF       = 10;  // 20 ns period
  localparam int    RESET_CYCLES   = 8;
  localparam int    INIT_BLOCKS    = 8;
  localparam int    CYCLES_PER_EVT = 200;
  localparam string STIM_FILE      = "verif/fetch_stimulus.txt";

  logic                               i_clk;
  logic                               i_reset_n;
  logic                               i_commit_valid;
  trap_pkg::except_t                  i_commit_cause;
  fetch_pkg::vaddr_t                  i_commit_epc;
  logic                               i_br_mispredict;
  fetch_pkg::vaddr_t                  i_br_target;
  fetch_pkg::vaddr_t                  i_mtvec;
  fetch_pkg::vaddr_t                  i_stvec;
  fetch_pkg::vaddr_t                  i_mepc;
  fetch_pkg::vaddr_t                  i_sepc;
  logic [trap_pkg::MEDELEG_W-1:0]     i_medeleg;
  logic                               o_mem_req_valid;
  fetch_pkg::vaddr_t                  o_mem_req_vaddr;
  logic                               i_mem_ready;
  logic                               i_mem_resp_valid;
  logic [fetch_pkg::FETCH_DATA_W-1:0] i_mem_resp_data;
  logic                               i_mem_miss;
  logic                               o_inst_valid;
  fetch_pkg::vaddr_t                  o_inst_pc;
  logic [fetch_pkg::FETCH_DATA_W-1:0] o_inst_data;
  logic                               i_inst_ready;

  // Event table from the stimulus file
  int                ev_kind[$];
  int                ev_cause[$];
  fetch_pkg::vaddr_t ev_epc[$];
  fetch_pkg::vaddr_t ev_tgt[$];
  fetch_pkg::vaddr_t ev_exp[$];
  int                ev_blocks[$];

  integer            seed = 69;
  bit                loaded;
  bit                load_ok;
  fetch_pkg::vaddr_t exp_pc;     // Next pc decode should see
  fetch_pkg::vaddr_t ev_expect;  // Target of the event being driven
  int                blk_count;  // Blocks seen since the last redirect
  int                n_checked;
  int                pc_errors;
  int                data_errors;
  logic              pend_valid;
  fetch_pkg::vaddr_t pend_addr;
  logic              miss_now;
  int                fill_cnt;

  frontend_fetch #(.IBUF_DEPTH(4)) UUT (.*);

  // Memory content, every address bit takes part
  function automatic logic [fetch_pkg::FETCH_DATA_W-1:0] block_data(
    input fetch_pkg::vaddr_t addr);
    return {addr[24:0], addr} ^ 64'hC3A5_5A3C_9669_0FF0;
  endfunction

  task automatic load_stimulus(output bit ok);
    int                             fd;
    int                             n;
    int                             kind;
    int                             cause;
    int                             blocks;
    string                          line;
    bit                             csr_done;
    fetch_pkg::vaddr_t              a0;
    fetch_pkg::vaddr_t              a1;
    fetch_pkg::vaddr_t              a2;
    fetch_pkg::vaddr_t              a3;
    logic [trap_pkg::MEDELEG_W-1:0] deleg;
    csr_done = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          if (!csr_done) begin
            n = $sscanf(line, "%h %h %h %h %h", a0, a1, a2, a3, deleg);
            if (n == 5) begin
              i_mtvec   = a0;
              i_stvec   = a1;
              i_mepc    = a2;
              i_sepc    = a3;
              i_medeleg = deleg;
              csr_done  = 1'b1;
            end
          end else begin
            n = $sscanf(line, "%d %d %h %h %h %d", kind, cause, a0, a1, a2, blocks);
            if (n == 6) begin
              ev_kind.push_back(kind);
              ev_cause.push_back(cause);
              ev_epc.push_back(a0);
              ev_tgt.push_back(a1);
              ev_exp.push_back(a2);
              ev_blocks.push_back(blocks);
            end
          end
        end
      end
      $fclose(fd);
    end
    ok = csr_done && (ev_kind.size() > 0);
  endtask

  task automatic wait_blocks(input int n);
    while (blk_count < n) @(posedge i_clk);
  endtask

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  // ==============================
  // Memory and decode models
  // ==============================
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      pend_valid <= o_mem_req_valid && i_mem_ready;  // Accepted this cycle
      pend_addr  <= o_mem_req_vaddr;
      miss_now = pend_valid && ({$random(seed)} % 8 == 0);
      i_mem_resp_valid <= pend_valid && !miss_now;
      i_mem_miss       <= miss_now;
      i_mem_resp_data  <= pend_valid ? block_data(pend_addr) : '0;
      if (miss_now) begin
        fill_cnt = 2 + {$random(seed)} % 4;  // Fill time
      end
      if (fill_cnt > 0) begin
        i_mem_ready <= 1'b0;
        fill_cnt--;
      end else begin
        i_mem_ready <= ({$random(seed)} % 8) != 0;
      end
      i_inst_ready <= ({$random(seed)} % 4) != 0;
    end
  end

  // ==============================
  // Decode side checker
  // ==============================
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      if (o_inst_valid && i_inst_ready) begin
        if (o_inst_pc !== exp_pc) begin
          $display("** Error at %0t ns: o_inst_pc = %h, expected %h", $time, o_inst_pc, exp_pc);
          pc_errors++;
        end
        if (o_inst_data !== block_data(exp_pc)) begin
          $display("** Error at %0t ns: o_inst_data = %h, expected %h",
                   $time, o_inst_data, block_data(exp_pc));
          data_errors++;
        end
        // Start of the following block
        exp_pc = exp_pc - (exp_pc % fetch_pkg::FETCH_BYTES) + fetch_pkg::FETCH_BYTES;
        n_checked++;
        blk_count <= blk_count + 1;
      end
      if (i_commit_valid || i_br_mispredict) begin  // Redirect lands at this edge
        exp_pc = ev_expect;
        blk_count <= 0;
      end
    end
  end

  initial begin
    i_reset_n        = 1'b0;
    i_commit_valid   = 1'b0;
    i_commit_cause   = trap_pkg::except_t'(5'd0);
    i_commit_epc     = '0;
    i_br_mispredict  = 1'b0;
    i_br_target      = '0;
    i_mtvec          = '0;
    i_stvec          = '0;
    i_mepc           = '0;
    i_sepc           = '0;
    i_medeleg        = '0;
    i_mem_ready      = 1'b1;
    i_mem_resp_valid = 1'b0;
    i_mem_resp_data  = '0;
    i_mem_miss       = 1'b0;
    i_inst_ready     = 1'b1;
    pend_valid       = 1'b0;
    pend_addr        = '0;
    fill_cnt         = 0;
    exp_pc           = fetch_pkg::PC_INIT_VAL;
    ev_expect        = '0;
    blk_count        = 0;
    n_checked        = 0;
    pc_errors        = 0;
    data_errors      = 0;
    loaded           = 1'b0;
    load_stimulus(load_ok);
    if (!load_ok) begin
      $display("Stimulus file is missing or holds no events");
      $display("Checks failed");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge i_clk);
      i_reset_n <= 1'b1;
      wait_blocks(INIT_BLOCKS);
      for (int i = 0; i < ev_kind.size(); i++) begin
        ev_expect = ev_exp[i];
        @(posedge i_clk);
        i_commit_valid  <= (ev_kind[i] != 1);  // Kind 0 commit, 1 mispredict, 2 both
        i_commit_cause  <= trap_pkg::except_t'(ev_cause[i]);
        i_commit_epc    <= ev_epc[i];
        i_br_mispredict <= (ev_kind[i] != 0);
        i_br_target     <= ev_tgt[i];
        @(posedge i_clk);
        i_commit_valid  <= 1'b0;
        i_br_mispredict <= 1'b0;
        @(posedge i_clk);
        wait_blocks(ev_blocks[i]);
      end
      @(negedge i_clk);
      $display("Blocks checked: %0d, pc errors: %0d, data errors: %0d, assertion failures: %0d",
               n_checked, pc_errors, data_errors, UUT.u_props.assert_fail_cnt);
      if (pc_errors + data_errors + UUT.u_props.assert_fail_cnt == 0 && n_checked > 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

  // Watchdog, one budget per event plus the boot stream
  initial begin
    wait (loaded);
    repeat (RESET_CYCLES + (ev_kind.size() + 1) * CYCLES_PER_EVT) @(posedge i_clk);
    $display("Watchdog expired, %0d blocks checked before the stream stalled", n_checked);
    $display("Checks failed");
    $finish;
  end

endmodule

/* verif/fetch_stimulus.txt */
# First data line: mtvec stvec mepc sepc medeleg (hex)
# Events: kind (0 commit, 1 mispredict, 2 both) cause epc br_target expected blocks
0080001000 0080002000 0080000400 0080000600 b104
0 26 0080000100 0000000000 0080000104 6
0 24 0080000300 0000000000 0080000400 5
0 25 0080000500 0000000000 0080000600 5
0 2 0080000820 0000000000 0080002000 4
0 1 0080000840 0000000000 0080001000 4
0 8 0080000860 0000000000 0080002000 4
0 9 0080000880 0000000000 0080001000 4
0 11 00800008a0 0000000000 0080001000 4
0 12 00800008c0 0000000000 0080002000 4
0 13 00800008e0 0000000000 0080002000 4
0 15 0080000900 0000000000 0080002000 4
0 0 0080000920 0000000000 0080001000 4
0 4 0080000940 0000000000 0080001000 4
0 5 0080000960 0000000000 0080001000 4
0 6 0080000980 0000000000 0080001000 4
0 7 00800009a0 0000000000 0080001000 4
1 0 0000000000 0080004010 0080004010 6
1 0 0000000000 0080005004 0080005004 6
2 24 0080000900 0080006000 0080000400 5
2 2 0080000a00 0080007000 0080002000 5
2 26 0080000208 0080008000 008000020c 5
1 0 0000000000 0080009000 0080009000 10
0 26 008000001c 0000000000 0080000020 4

/* src.f */
common/fetch_pkg.sv
common/trap_pkg.sv
design/fetch_redirect.sv
fetch/fetch_pc_ctrl.sv
fetch/fetch_pipe.sv
design/inst_buffer.sv
design/frontend_fetch.sv
verif/frontend_fetch_properties.sv
verif/tb_frontend_fetch.sv

/* Bender.yml */
package:
  name: frontend_fetch

sources:
  - common/fetch_pkg.sv
  - common/trap_pkg.sv
  - design/fetch_redirect.sv
  - fetch/fetch_pc_ctrl.sv
  - fetch/fetch_pipe.sv
  - design/inst_buffer.sv
  - design/frontend_fetch.sv
  - target: test
    files:
      - verif/frontend_fetch_properties.sv
      - verif/tb_frontend_fetch.sv
